/* Bender.yml */
package:
  name: des_engine

sources:
  - files:
      - design/des_pkg.sv
      - design/des_sbox.sv
      - design/des_feistel.sv
      - design/des_key_sched.sv
      - design/des_round_ctrl.sv
      - design/des_top.sv
  - target: test
    files:
      - sim/des_tb.sv

/* design/des_feistel.sv */
// DES round function: expansion, key mixing, substitution and P permutation
`timescale 1ns/1ps

module des_feistel
	import des_pkg::*;
(
	input  des_half_t   r_half,
	input  des_subkey_t subkey,
	output des_half_t   f_out
);

	des_subkey_t expanded;
	des_subkey_t mixed;
	des_half_t   sub_bits;

	// 32 to 48 bits, edge bits of each nibble duplicated
	assign expanded = des_expand(r_half);
	assign mixed    = expanded ^ subkey;

	// Box 1 takes the top six bits and fills the top nibble
	for (genvar i = 0; i < 8; i++) begin : g_sbox
		des_sbox #(
			.SBOX_INDEX(i)
		) u_sbox (
			.sub_in (mixed[47 - 6 * i -: 6]),
			.sub_out(sub_bits[31 - 4 * i -: 4])
		);
	end

	assign f_out = des_pperm(sub_bits);

endmodule

/* design/des_key_sched.sv */
// DES key schedule: PC-1 on load, per-round C/D rotation and PC-2 round key
`timescale 1ns/1ps

module des_key_sched
	import des_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        load,
	input  des_key_t    key,
	input  logic        decrypt,
	input  logic        advance,
	output des_subkey_t subkey
);

	logic [55:0] pc1_bits;
	des_cd_t     c_half;
	des_cd_t     d_half;
	des_cd_t     c_init;
	des_cd_t     d_init;
	des_round_t  rnd;
	des_round_t  shift_idx;
	logic        dec;

	function automatic des_cd_t rot_left(des_cd_t x, logic [1:0] n);
		return (n == 2'd2) ? {x[25:0], x[27:26]} : {x[26:0], x[27]};
	endfunction

	function automatic des_cd_t rot_right(des_cd_t x, logic [1:0] n);
		return (n == 2'd2) ? {x[1:0], x[27:2]} : {x[0], x[27:1]};
	endfunction

	assign pc1_bits = des_pc1(key);
	assign c_init   = pc1_bits[55:28];
	assign d_init   = pc1_bits[27:0];

	// Decryption walks the shift list backwards from round 16
	assign shift_idx = dec ? (4'd15 - rnd) : (rnd + 4'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			rnd <= '0;
			dec <= 1'b0;
		end else if (load) begin
			rnd <= '0;
			dec <= decrypt;
		end else if (advance) begin
			rnd <= rnd + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			// K16 has 28 shifts in total, so decryption starts unrotated
			if (decrypt) begin
				c_half <= c_init;
				d_half <= d_init;
			end else begin
				c_half <= rot_left(c_init, SHIFT_TABLE[0]);
				d_half <= rot_left(d_init, SHIFT_TABLE[0]);
			end
		end else if (advance) begin
			if (dec) begin
				c_half <= rot_right(c_half, SHIFT_TABLE[shift_idx]);
				d_half <= rot_right(d_half, SHIFT_TABLE[shift_idx]);
			end else begin
				c_half <= rot_left(c_half, SHIFT_TABLE[shift_idx]);
				d_half <= rot_left(d_half, SHIFT_TABLE[shift_idx]);
			end
		end
	end

	assign subkey = des_pc2(c_half, d_half);

endmodule

/* design/des_pkg.sv */
// DES shared types, S-box contents, permutation tables and permutation helpers
package des_pkg;

	typedef logic [63:0] des_block_t;
	typedef logic [31:0] des_half_t;
	typedef logic [63:0] des_key_t;
	typedef logic [27:0] des_cd_t;
	typedef logic [47:0] des_subkey_t;
	typedef logic [3:0]  des_round_t;

	typedef enum logic {
		IDLE,
		ROUND
	} des_state_e;

	// Box by row, column 0 in the top nibble
	localparam logic [63:0] SBOX_TABLE [8][4] = '{
		'{64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
		  64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
		'{64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
		  64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
		'{64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
		  64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
		'{64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
		  64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
		'{64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
		  64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
		'{64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
		  64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
		'{64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
		  64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
		'{64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
		  64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}
	};

	// Bit numbers count from 1 at the MSB, as in the standard
	localparam byte unsigned IP_TABLE [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam byte unsigned FP_TABLE [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
	};

	localparam byte unsigned E_TABLE [48] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
	};

	localparam byte unsigned P_TABLE [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
	};

	// Parity bits 8, 16, ... 64 never appear here
	localparam byte unsigned PC1_TABLE [56] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};

	localparam byte unsigned PC2_TABLE [48] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	// Left rotation per round, 28 in total
	localparam logic [1:0] SHIFT_TABLE [16] = '{
		2'd1, 2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2,
		2'd1, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd2, 2'd1
	};

	function automatic des_block_t des_ip(des_block_t blk);
		des_block_t res;
		for (int i = 0; i < 64; i++) begin
			res[63 - i] = blk[64 - IP_TABLE[i]];
		end
		return res;
	endfunction

	function automatic des_block_t des_fp(des_block_t blk);
		des_block_t res;
		for (int i = 0; i < 64; i++) begin
			res[63 - i] = blk[64 - FP_TABLE[i]];
		end
		return res;
	endfunction

	function automatic des_subkey_t des_expand(des_half_t half);
		des_subkey_t res;
		for (int i = 0; i < 48; i++) begin
			res[47 - i] = half[32 - E_TABLE[i]];
		end
		return res;
	endfunction

	function automatic des_half_t des_pperm(des_half_t half);
		des_half_t res;
		for (int i = 0; i < 32; i++) begin
			res[31 - i] = half[32 - P_TABLE[i]];
		end
		return res;
	endfunction

	// C in the upper 28 bits, D in the lower
	function automatic logic [55:0] des_pc1(des_key_t key);
		logic [55:0] res;
		for (int i = 0; i < 56; i++) begin
			res[55 - i] = key[64 - PC1_TABLE[i]];
		end
		return res;
	endfunction

	function automatic des_subkey_t des_pc2(des_cd_t c, des_cd_t d);
		logic [55:0] cd;
		des_subkey_t res;
		cd = {c, d};
		for (int i = 0; i < 48; i++) begin
			res[47 - i] = cd[56 - PC2_TABLE[i]];
		end
		return res;
	endfunction

endpackage

/* design/des_round_ctrl.sv */
// DES round engine: IP, 16 Feistel rounds at one per clock, swap and FP
`timescale 1ns/1ps

module des_round_ctrl
	import des_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  des_block_t block,
	input  des_key_t   key,
	input  logic       decrypt,
	output logic       done,
	output des_block_t result
);

	des_state_e  state;
	des_round_t  rnd;
	des_half_t   l_half;
	des_half_t   r_half;
	des_half_t   f_out;
	des_subkey_t subkey;
	des_block_t  ip_block;
	logic        load;
	logic        advance;
	logic        last_round;

	assign load       = start && (state == IDLE);
	assign advance    = (state == ROUND);
	assign last_round = advance && (rnd == 4'd15);
	assign ip_block   = des_ip(block);

	des_key_sched u_key_sched (
		.clk    (clk),
		.rst    (rst),
		.load   (load),
		.key    (key),
		.decrypt(decrypt),
		.advance(advance),
		.subkey (subkey)
	);

	des_feistel u_feistel (
		.r_half(r_half),
		.subkey(subkey),
		.f_out (f_out)
	);

	// Control
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			rnd   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						state <= ROUND;
						rnd   <= '0;
					end
				end
				ROUND: begin
					rnd <= rnd + 4'd1;
					if (rnd == 4'd15) begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		if (load) begin
			l_half <= ip_block[63:32];
			r_half <= ip_block[31:0];
		end else if (advance) begin
			l_half <= r_half;
			r_half <= l_half ^ f_out;
		end
	end

	// Preoutput is R16 then L16, so the last round lands swapped
	always_ff @(posedge clk) begin
		if (last_round) begin
			result <= des_fp({l_half ^ f_out, r_half});
		end
	end

endmodule

/* design/des_sbox.sv */
// DES substitution box, 6-bit input to 4-bit output from the chosen table
`timescale 1ns/1ps

module des_sbox
	import des_pkg::*;
#(
	parameter int SBOX_INDEX = 0
)
(
	input  logic [5:0] sub_in,
	output logic [3:0] sub_out
);

	logic [1:0]  row;
	logic [3:0]  col;
	logic [63:0] row_bits;

	// Outer bits pick the row, inner four the column
	assign row = {sub_in[5], sub_in[0]};
	assign col = sub_in[4:1];

	always_comb begin : substitution
		row_bits = SBOX_TABLE[SBOX_INDEX][row];
		// Column 0 sits in the top nibble
		sub_out = row_bits[4 * (15 - col) +: 4];
	end

endmodule

/* design/des_top.sv */
// DES engine top: input slot with credit grants, output credits and output register
`timescale 1ns/1ps

module des_top
	import des_pkg::*;
#(
	parameter int OUT_CREDITS_MAX = 4
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  des_block_t in_data,
	input  des_key_t   in_key,
	input  logic       in_decrypt,
	output logic       in_credit,
	input  logic       out_credit,
	output logic       out_valid,
	output des_block_t out_data
);

	localparam int CNT_W = $clog2(OUT_CREDITS_MAX + 1);

	logic             slot_full;
	des_block_t       slot_data;
	des_key_t         slot_key;
	logic             slot_dec;
	logic             granted;
	logic             busy;
	logic             engine_idle;
	logic             start;
	logic             done;
	des_block_t       result;
	logic [CNT_W-1:0] out_cnt;

	// Engine returns to IDLE on the same edge that raises done
	assign engine_idle = !busy || done;
	assign start       = slot_full && engine_idle && (out_cnt != '0);

	des_round_ctrl u_round_ctrl (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.block  (slot_data),
		.key    (slot_key),
		.decrypt(slot_dec),
		.done   (done),
		.result (result)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_full <= 1'b0;
			granted   <= 1'b0;
			in_credit <= 1'b0;
			busy      <= 1'b0;
		end else begin
			granted   <= 1'b1;
			// First grant after reset, then one per hand-off
			in_credit <= start || !granted;
			busy      <= start || (busy && !done);
			if (start) begin
				slot_full <= 1'b0;
			end
			if (in_valid) begin
				slot_full <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			slot_data <= in_data;
			slot_key  <= in_key;
			slot_dec  <= in_decrypt;
		end
	end

	// Output credits, saturating at OUT_CREDITS_MAX
	always_ff @(posedge clk) begin
		if (rst) begin
			out_cnt <= '0;
		end else if (out_credit && !start) begin
			if (out_cnt != CNT_W'(OUT_CREDITS_MAX)) begin
				out_cnt <= out_cnt + 1'b1;
			end
		end else if (start && !out_credit) begin
			out_cnt <= out_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= done;
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			out_data <= result;
		end
	end

endmodule

/* flist.f */
design/des_pkg.sv
design/des_sbox.sv
design/des_feistel.sv
design/des_key_sched.sv
design/des_round_ctrl.sv
design/des_top.sv
sim/des_tb.sv

/* sim/des_tb.sv */
// Testbench for the DES engine with a bit-serial reference, credit source and sink
`timescale 1ns/1ps

module des_tb
	import des_pkg::*;
();

	logic        clk;
	logic        rst;
	logic        in_valid;
	des_block_t  in_data;
	des_key_t    in_key;
	logic        in_decrypt;
	logic        in_credit;
	logic        out_credit;
	logic        out_valid;
	des_block_t  out_data;
	logic [31:0] rng_state;
	des_block_t  expected_q [$];
	string       test_name;
	int          tx_credits;
	// One grant plus one per block accepted, minus in_credit pulses seen
	int          in_balance;
	// out_credit pulses sent minus out_valid pulses seen
	int          out_balance;
	int          sink_owed;
	logic        sink_enable;

	des_top #(.OUT_CREDITS_MAX(4)) u_des_top (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
		if (exp !== act) begin
			abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// Two LCG steps per call
	function automatic logic [63:0] lcg64();
		logic [31:0] hi;
		hi = rng_state * 32'd1664525 + 32'd1013904223;
		rng_state = hi * 32'd1664525 + 32'd1013904223;
		return {hi, rng_state};
	endfunction

	// Bit-serial DES straight from the standard tables
	function automatic des_block_t des_ref(des_block_t blk, des_key_t key, logic dec);
		logic [55:0] cd;
		des_subkey_t ks [16];
		des_subkey_t x;
		des_half_t   l;
		des_half_t   r;
		des_half_t   sb;
		des_half_t   fr;
		logic [63:0] t;
		for (int i = 0; i < 56; i++) begin
			cd[55 - i] = key[64 - PC1_TABLE[i]];
		end
		// Kn from the cumulative left shifts of C and D
		for (int n = 0; n < 16; n++) begin
			repeat (SHIFT_TABLE[n]) begin
				cd = {cd[54:28], cd[55], cd[26:0], cd[27]};
			end
			for (int i = 0; i < 48; i++) begin
				ks[n][47 - i] = cd[56 - PC2_TABLE[i]];
			end
		end
		for (int i = 0; i < 64; i++) begin
			t[63 - i] = blk[64 - IP_TABLE[i]];
		end
		{l, r} = t;
		for (int n = 0; n < 16; n++) begin
			for (int i = 0; i < 48; i++) begin
				x[47 - i] = r[32 - E_TABLE[i]];
			end
			// Decryption takes the round keys in reverse
			x = x ^ ks[dec ? 15 - n : n];
			for (int b = 0; b < 8; b++) begin
				t = SBOX_TABLE[b][{x[47 - 6 * b], x[42 - 6 * b]}];
				sb[31 - 4 * b -: 4] = t[60 - 4 * x[46 - 6 * b -: 4] +: 4];
			end
			for (int i = 0; i < 32; i++) begin
				fr[31 - i] = sb[32 - P_TABLE[i]];
			end
			{l, r} = {r, l ^ fr};
		end
		// Preoutput is R16 followed by L16
		blk = {r, l};
		for (int i = 0; i < 64; i++) begin
			t[63 - i] = blk[64 - FP_TABLE[i]];
		end
		return t;
	endfunction

	// Sink frees one buffer entry per result and returns it as a credit
	always @(posedge clk) begin
		#1;
		out_credit = sink_enable && (sink_owed > 0);
		if (out_credit) begin
			sink_owed--;
			out_balance++;
		end
	end

	// DUT outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!rst && in_credit) begin
			tx_credits++;
			in_balance--;
		end
		if (!rst && out_valid) begin
			sink_owed++;
			out_balance--;
			if (expected_q.size() == 0) begin
				abort_run("out_valid pulsed with no block outstanding");
			end else begin
				check_value({test_name, " result"}, expected_q.pop_front(), out_data);
			end
		end
		if (in_balance < 0) begin
			abort_run("more in_credit pulses than one plus the blocks accepted");
		end else if (out_balance < 0) begin
			abort_run("more out_valid pulses than out_credit pulses granted");
		end
	end

	task automatic send_block(des_block_t blk, des_key_t key, logic dec, des_block_t exp);
		int waited;
		waited = 0;
		while (tx_credits == 0 && waited < 300) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (tx_credits == 0) begin
			abort_run("no input credit came back within 300 cycles");
		end
		in_valid   = 1'b1;
		in_data    = blk;
		in_key     = key;
		in_decrypt = dec;
		tx_credits--;
		in_balance++;
		expected_q.push_back(exp);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	// Wait until at most level results are outstanding and the sink has paid back
	task automatic wait_pending(int level, int limit);
		int waited;
		waited = 0;
		while ((expected_q.size() > level || (sink_enable && sink_owed != 0))
			&& waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() > level || (sink_enable && sink_owed != 0)) begin
			abort_run("timed out waiting for outstanding results");
		end
		#1;
	endtask

	initial begin
		des_key_t    key;
		des_block_t  pt;
		des_block_t  ct;
		logic [63:0] rnd;
		int          lat;
		rng_state   = 32'h39b34f8f;
		rst         = 1'b1;
		in_valid    = 1'b0;
		in_data     = '0;
		in_key      = '0;
		in_decrypt  = 1'b0;
		out_credit  = 1'b0;
		tx_credits  = 0;
		in_balance  = 1;
		out_balance = 0;
		// Sink starts with room for four results
		sink_owed   = 4;
		sink_enable = 1'b0;
		test_name   = "reset";
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		sink_enable = 1'b1;
		@(posedge clk);
		#1;

		// Textbook vector and its decryption
		test_name = "known answer";
		check_value("known answer reference", 64'h85E813540F0AB405,
			des_ref(64'h0123456789ABCDEF, 64'h133457799BBCDFF1, 1'b0));
		send_block(64'h0123456789ABCDEF, 64'h133457799BBCDFF1, 1'b0, 64'h85E813540F0AB405);
		send_block(64'h85E813540F0AB405, 64'h133457799BBCDFF1, 1'b1, 64'h0123456789ABCDEF);
		wait_pending(0, 200);

		test_name = "round trip";
		for (int i = 0; i < 50; i++) begin
			key = lcg64();
			pt  = lcg64();
			ct  = des_ref(pt, key, 1'b0);
			send_block(pt, key, 1'b0, ct);
			send_block(ct, key, 1'b1, pt);
		end
		wait_pending(0, 200);

		test_name = "random traffic";
		for (int i = 0; i < 200; i++) begin
			key = lcg64();
			pt  = lcg64();
			rnd = lcg64();
			send_block(pt, key, rnd[47], des_ref(pt, key, rnd[47]));
		end
		wait_pending(0, 200);

		// Four stored credits let four blocks through while the fifth waits in the slot
		test_name = "back-pressure";
		@(negedge clk);
		sink_enable = 1'b0;
		@(posedge clk);
		#1;
		for (int i = 0; i < 5; i++) begin
			key = lcg64();
			pt  = lcg64();
			send_block(pt, key, 1'b0, des_ref(pt, key, 1'b0));
		end
		wait_pending(1, 300);
		for (int i = 0; i < 100; i++) begin
			@(negedge clk);
			check_value("back-pressure out_valid", 0, out_valid);
		end
		sink_enable = 1'b1;
		wait_pending(0, 200);

		// Idle engine with credits takes one cycle to start plus 17
		test_name = "latency";
		key = lcg64();
		pt  = lcg64();
		send_block(pt, key, 1'b1, des_ref(pt, key, 1'b1));
		lat = 0;
		@(negedge clk);
		while (!out_valid && lat < 100) begin
			@(negedge clk);
			lat++;
		end
		if (!out_valid) begin
			abort_run("out_valid never came in the latency test");
		end
		check_value("latency", 18, lat);
		wait_pending(0, 200);
		check_value("input credits held when idle", 1, tx_credits);
		$display("TB PASSED");
		$finish;
	end

endmodule
